// File: design/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate (
    input  lsu_pkg::addr_t  vaddr,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            crmd_pg,
    input  lsu_pkg::plv_t   crmd_plv,
    input  lsu_pkg::asid_t  asid,
    input  logic            dmw0_plv_met,
    input  logic [2:0]      dmw0_vseg,
    input  logic [2:0]      dmw0_pseg,
    input  logic            dmw1_plv_met,
    input  logic [2:0]      dmw1_vseg,
    input  logic [2:0]      dmw1_pseg,
    output lsu_pkg::vppn_t  s_vppn,
    output logic            s_va_bit12,
    output logic            s_va_bit21,
    output lsu_pkg::asid_t  s_asid,
    input  logic            s_found,
    input  lsu_pkg::ppn_t   s_ppn,
    input  logic [5:0]      s_ps,
    input  lsu_pkg::plv_t   s_plv,
    input  logic            s_d,
    input  logic            s_v,
    output lsu_pkg::addr_t  pa,
    output logic            xlate_excep,
    output lsu_pkg::ecode_t xlate_ecode
);
    logic           hit_dmw0;
    logic           hit_dmw1;
    logic           use_tlb;
    lsu_pkg::addr_t tlb_pa;

    assign s_vppn     = vaddr[31:13];
    assign s_va_bit12 = vaddr[12];
    assign s_va_bit21 = vaddr[21];
    assign s_asid     = asid;

    assign hit_dmw0 = dmw0_plv_met && dmw0_vseg == vaddr[31:29];
    assign hit_dmw1 = dmw1_plv_met && dmw1_vseg == vaddr[31:29];
    assign use_tlb  = crmd_pg && !hit_dmw0 && !hit_dmw1 && (is_load || is_store);

    assign tlb_pa = (s_ps == lsu_pkg::PS_4M) ? {s_ppn[19:9], vaddr[20:0]}
                                             : {s_ppn, vaddr[11:0]};

    always_comb begin
        if (!crmd_pg) begin
            pa = vaddr;                                 // direct mode
        end else if (hit_dmw0) begin
            pa = {dmw0_pseg, vaddr[28:0]};
        end else if (hit_dmw1) begin
            pa = {dmw1_pseg, vaddr[28:0]};
        end else begin
            pa = tlb_pa;
        end
    end

    // page faults only exist on the mapped path
    always_comb begin
        xlate_excep = use_tlb;
        if (!s_found) begin
            xlate_ecode = lsu_pkg::ECODE_TLBR;
        end else if (!s_v) begin
            xlate_ecode = is_store ? lsu_pkg::ECODE_PIS : lsu_pkg::ECODE_PIL;
        end else if (s_plv > crmd_plv) begin
            xlate_ecode = lsu_pkg::ECODE_PPI;
        end else if (is_store && !s_d) begin
            xlate_ecode = lsu_pkg::ECODE_PME;
        end else begin
            xlate_excep = 1'b0;                         // clean hit
            xlate_ecode = '0;
        end
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  logic              in_valid,
    input  lsu_pkg::mem_op_t  in_op,
    input  lsu_pkg::word_t    in_base,
    input  lsu_pkg::word_t    in_offset,
    input  lsu_pkg::word_t    in_st_data,
    input  lsu_pkg::reg_idx_t in_rd,
    output logic              in_allowin,
    output lsu_pkg::addr_t    ex_vaddr,
    output logic              ex_is_load,
    output logic              ex_is_store,
    input  lsu_pkg::addr_t    pa,
    input  logic              xlate_excep,
    input  lsu_pkg::ecode_t   xlate_ecode,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [1:0]        data_sram_size,
    output logic [3:0]        data_sram_wstrb,
    output lsu_pkg::addr_t    data_sram_addr,
    output lsu_pkg::word_t    data_sram_wdata,
    input  logic              data_sram_addr_ok,
    input  logic              mem_allowin,
    output logic              ex_to_mem_valid,
    output lsu_pkg::reg_idx_t ex_to_mem_rd,
    output lsu_pkg::mem_op_t  ex_to_mem_op,
    output logic [1:0]        ex_to_mem_lowaddr,
    output logic              ex_to_mem_excep,
    output lsu_pkg::ecode_t   ex_to_mem_ecode,
    output lsu_pkg::addr_t    ex_to_mem_badv,
    output logic              ex_to_mem_has_req
);
    logic              ex_valid;
    lsu_pkg::mem_op_t  ex_op;
    lsu_pkg::word_t    ex_base;
    lsu_pkg::word_t    ex_offset;
    lsu_pkg::word_t    ex_st_data;
    lsu_pkg::reg_idx_t ex_rd;
    logic [1:0]        acc_size;     // 0 byte, 1 half, 2 word
    logic              is_st;
    logic              ale;
    logic              ex_excep;
    logic              ex_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_op      <= in_op;
            ex_base    <= in_base;
            ex_offset  <= in_offset;
            ex_st_data <= in_st_data;
            ex_rd      <= in_rd;
        end
    end

    always_comb begin
        case (ex_op)
            lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_ST_B: acc_size = 2'd0;
            lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_HU, lsu_pkg::OP_ST_H: acc_size = 2'd1;
            default:                                               acc_size = 2'd2;
        endcase
    end

    assign is_st       = ex_op inside {lsu_pkg::OP_ST_B, lsu_pkg::OP_ST_H, lsu_pkg::OP_ST_W};
    assign ex_vaddr    = ex_base + ex_offset;
    assign ex_is_load  = ex_valid && !is_st;
    assign ex_is_store = ex_valid && is_st;

    assign ale = ex_valid && ((acc_size == 2'd1 && ex_vaddr[0])
                           || (acc_size == 2'd2 && ex_vaddr[1:0] != 2'b00));
    assign ex_excep = ale || xlate_excep;

    // excepting access never reaches the bus
    assign data_sram_req   = ex_valid && !ex_excep && !flush && mem_allowin;
    assign data_sram_wr    = is_st;
    assign data_sram_size  = acc_size;
    assign data_sram_addr  = pa;

    always_comb begin
        case (acc_size)
            2'd0: begin
                data_sram_wstrb = 4'b0001 << ex_vaddr[1:0];
                data_sram_wdata = {4{ex_st_data[7:0]}};
            end
            2'd1: begin
                data_sram_wstrb = ex_vaddr[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{ex_st_data[15:0]}};
            end
            default: begin
                data_sram_wstrb = 4'b1111;
                data_sram_wdata = ex_st_data;
            end
        endcase
        if (!is_st) begin
            data_sram_wstrb = 4'b0000;                // loads write nothing
        end
    end

    assign ex_ready_go = (data_sram_req && data_sram_addr_ok) || ex_excep;
    assign in_allowin  = !ex_valid || (ex_ready_go && mem_allowin);

    assign ex_to_mem_valid   = ex_valid && ex_ready_go;
    assign ex_to_mem_rd      = ex_rd;
    assign ex_to_mem_op      = ex_op;
    assign ex_to_mem_lowaddr = ex_vaddr[1:0];          // same in va and pa
    assign ex_to_mem_excep   = ex_excep;
    assign ex_to_mem_ecode   = ale ? lsu_pkg::ECODE_ALE : xlate_ecode;
    assign ex_to_mem_badv    = ex_vaddr;
    assign ex_to_mem_has_req = !ex_excep;

endmodule

// File: design/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] addr_t;     // virtual or physical address
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [18:0] vppn_t;     // va[31:13], one even/odd page pair
    typedef logic [19:0] ppn_t;
    typedef logic [1:0]  plv_t;
    typedef logic [9:0]  asid_t;
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [5:0]  ecode_t;

    // loads first, stores from OP_ST_B up
    typedef enum logic [2:0] {
        OP_LD_B  = 3'd0,
        OP_LD_H  = 3'd1,
        OP_LD_W  = 3'd2,
        OP_LD_BU = 3'd3,
        OP_LD_HU = 3'd4,
        OP_ST_B  = 3'd5,
        OP_ST_H  = 3'd6,
        OP_ST_W  = 3'd7
    } mem_op_t;

    localparam int TLB_ENTRIES = 16;

    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    localparam ecode_t ECODE_PIL  = 6'h01;   // load from invalid page
    localparam ecode_t ECODE_PIS  = 6'h02;   // store to invalid page
    localparam ecode_t ECODE_PME  = 6'h04;   // store to clean page
    localparam ecode_t ECODE_PPI  = 6'h07;   // privilege violation
    localparam ecode_t ECODE_ALE  = 6'h09;   // misaligned access
    localparam ecode_t ECODE_TLBR = 6'h3f;   // tlb refill

endpackage

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  logic              in_valid,
    input  lsu_pkg::mem_op_t  in_op,
    input  lsu_pkg::word_t    in_base,
    input  lsu_pkg::word_t    in_offset,
    input  lsu_pkg::word_t    in_st_data,
    input  lsu_pkg::reg_idx_t in_rd,
    output logic              in_allowin,
    input  logic              crmd_pg,
    input  lsu_pkg::plv_t     crmd_plv,
    input  lsu_pkg::asid_t    asid,
    input  logic              dmw0_plv_met,
    input  logic [2:0]        dmw0_vseg,
    input  logic [2:0]        dmw0_pseg,
    input  logic              dmw1_plv_met,
    input  logic [2:0]        dmw1_vseg,
    input  logic [2:0]        dmw1_pseg,
    input  logic              tlb_we,
    input  lsu_pkg::tlb_idx_t tlb_w_index,
    input  lsu_pkg::vppn_t    tlb_w_vppn,
    input  logic              tlb_w_ps4m,
    input  logic              tlb_w_g,
    input  lsu_pkg::asid_t    tlb_w_asid,
    input  lsu_pkg::ppn_t     tlb_w_ppn0,
    input  lsu_pkg::ppn_t     tlb_w_ppn1,
    input  lsu_pkg::plv_t     tlb_w_plv0,
    input  lsu_pkg::plv_t     tlb_w_plv1,
    input  logic              tlb_w_d0,
    input  logic              tlb_w_d1,
    input  logic              tlb_w_v0,
    input  logic              tlb_w_v1,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [1:0]        data_sram_size,
    output logic [3:0]        data_sram_wstrb,
    output lsu_pkg::addr_t    data_sram_addr,
    output lsu_pkg::word_t    data_sram_wdata,
    input  logic              data_sram_addr_ok,
    input  logic              data_sram_data_ok,
    input  lsu_pkg::word_t    data_sram_rdata,
    output logic              wb_valid,
    output logic              wb_we,
    output lsu_pkg::reg_idx_t wb_rd,
    output lsu_pkg::word_t    wb_data,
    output logic              wb_excep,
    output lsu_pkg::ecode_t   wb_ecode,
    output lsu_pkg::addr_t    wb_badv
);
    lsu_pkg::addr_t    ex_vaddr;
    logic              ex_is_load;
    logic              ex_is_store;
    lsu_pkg::addr_t    pa;
    logic              xlate_excep;
    lsu_pkg::ecode_t   xlate_ecode;
    logic              mem_allowin;
    logic              ex_to_mem_valid;
    lsu_pkg::reg_idx_t ex_to_mem_rd;
    lsu_pkg::mem_op_t  ex_to_mem_op;
    logic [1:0]        ex_to_mem_lowaddr;
    logic              ex_to_mem_excep;
    lsu_pkg::ecode_t   ex_to_mem_ecode;
    lsu_pkg::addr_t    ex_to_mem_badv;
    logic              ex_to_mem_has_req;
    lsu_pkg::vppn_t    s_vppn;
    logic              s_va_bit12;
    logic              s_va_bit21;
    lsu_pkg::asid_t    s_asid;
    logic              s_found;
    lsu_pkg::ppn_t     s_ppn;
    logic [5:0]        s_ps;
    lsu_pkg::plv_t     s_plv;
    logic              s_d;
    logic              s_v;

    ex_stage u_ex (.*);

    addr_xlate u_xlate (
        .vaddr    (ex_vaddr),
        .is_load  (ex_is_load),
        .is_store (ex_is_store),
        .*
    );

    tlb_lookup u_tlb (
        .s_index (),            // no tlb instructions in this slice
        .*
    );

    mem_stage u_mem (.*);

endmodule

// File: design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  logic              ex_to_mem_valid,
    input  lsu_pkg::reg_idx_t ex_to_mem_rd,
    input  lsu_pkg::mem_op_t  ex_to_mem_op,
    input  logic [1:0]        ex_to_mem_lowaddr,
    input  logic              ex_to_mem_excep,
    input  lsu_pkg::ecode_t   ex_to_mem_ecode,
    input  lsu_pkg::addr_t    ex_to_mem_badv,
    input  logic              ex_to_mem_has_req,
    output logic              mem_allowin,
    input  logic              data_sram_data_ok,
    input  lsu_pkg::word_t    data_sram_rdata,
    output logic              wb_valid,
    output logic              wb_we,
    output lsu_pkg::reg_idx_t wb_rd,
    output lsu_pkg::word_t    wb_data,
    output logic              wb_excep,
    output lsu_pkg::ecode_t   wb_ecode,
    output lsu_pkg::addr_t    wb_badv
);
    logic              mem_valid;
    logic              mem_discard;   // swallow one data_ok after flush
    lsu_pkg::reg_idx_t mem_rd;
    lsu_pkg::mem_op_t  mem_op;
    logic [1:0]        mem_lowaddr;
    logic              mem_excep;
    lsu_pkg::ecode_t   mem_ecode;
    lsu_pkg::addr_t    mem_badv;
    logic              mem_has_req;
    logic              mem_done;
    lsu_pkg::word_t    shifted;
    lsu_pkg::word_t    ld_data;

    assign mem_done    = mem_valid && (!mem_has_req || data_sram_data_ok);
    assign mem_allowin = !mem_discard && (!mem_valid || mem_done);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_discard <= 1'b0;
        end else if (flush && mem_valid && mem_has_req && !data_sram_data_ok) begin
            mem_discard <= 1'b1;
        end else if (data_sram_data_ok) begin
            mem_discard <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_rd      <= ex_to_mem_rd;
            mem_op      <= ex_to_mem_op;
            mem_lowaddr <= ex_to_mem_lowaddr;
            mem_excep   <= ex_to_mem_excep;
            mem_ecode   <= ex_to_mem_ecode;
            mem_badv    <= ex_to_mem_badv;
            mem_has_req <= ex_to_mem_has_req;
        end
    end

    assign shifted = data_sram_rdata >> {mem_lowaddr, 3'b000};

    always_comb begin
        case (mem_op)
            lsu_pkg::OP_LD_B:  ld_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::OP_LD_BU: ld_data = {24'b0, shifted[7:0]};
            lsu_pkg::OP_LD_H:  ld_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::OP_LD_HU: ld_data = {16'b0, shifted[15:0]};
            default:           ld_data = data_sram_rdata;
        endcase
    end

    // flush drops a result completing in the same cycle
    assign wb_valid = mem_done && !flush;
    assign wb_we    = wb_valid && !mem_excep && mem_op inside {lsu_pkg::OP_LD_B,
                      lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_W, lsu_pkg::OP_LD_BU, lsu_pkg::OP_LD_HU};
    assign wb_data  = wb_we ? ld_data : '0;
    assign wb_rd    = mem_rd;
    assign wb_excep = mem_excep;
    assign wb_ecode = mem_ecode;
    assign wb_badv  = mem_badv;

endmodule

// File: design/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  logic              clk,
    input  logic              resetn,
    input  logic              tlb_we,
    input  lsu_pkg::tlb_idx_t tlb_w_index,
    input  lsu_pkg::vppn_t    tlb_w_vppn,
    input  logic              tlb_w_ps4m,
    input  logic              tlb_w_g,
    input  lsu_pkg::asid_t    tlb_w_asid,
    input  lsu_pkg::ppn_t     tlb_w_ppn0,
    input  lsu_pkg::ppn_t     tlb_w_ppn1,
    input  lsu_pkg::plv_t     tlb_w_plv0,
    input  lsu_pkg::plv_t     tlb_w_plv1,
    input  logic              tlb_w_d0,
    input  logic              tlb_w_d1,
    input  logic              tlb_w_v0,
    input  logic              tlb_w_v1,
    input  lsu_pkg::vppn_t    s_vppn,
    input  logic              s_va_bit12,
    input  logic              s_va_bit21,
    input  lsu_pkg::asid_t    s_asid,
    output logic              s_found,
    output lsu_pkg::tlb_idx_t s_index,
    output lsu_pkg::ppn_t     s_ppn,
    output logic [5:0]        s_ps,
    output lsu_pkg::plv_t     s_plv,
    output logic              s_d,
    output logic              s_v
);
    localparam int N = lsu_pkg::TLB_ENTRIES;

    logic [N-1:0]   tlb_e;                 // entry present
    lsu_pkg::vppn_t tlb_vppn [N];
    logic [N-1:0]   tlb_ps4m;
    logic [N-1:0]   tlb_g;
    lsu_pkg::asid_t tlb_asid [N];
    lsu_pkg::ppn_t  tlb_ppn  [N][2];       // [entry][odd page]
    lsu_pkg::plv_t  tlb_plv  [N][2];
    logic [1:0]     tlb_d    [N];          // {odd, even}
    logic [1:0]     tlb_v    [N];
    logic [N-1:0]   match;
    logic           odd;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tlb_e <= '0;
        end else if (tlb_we) begin
            tlb_e[tlb_w_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            tlb_vppn[tlb_w_index]   <= tlb_w_vppn;
            tlb_ps4m[tlb_w_index]   <= tlb_w_ps4m;
            tlb_g[tlb_w_index]      <= tlb_w_g;
            tlb_asid[tlb_w_index]   <= tlb_w_asid;
            tlb_ppn[tlb_w_index][0] <= tlb_w_ppn0;
            tlb_ppn[tlb_w_index][1] <= tlb_w_ppn1;
            tlb_plv[tlb_w_index][0] <= tlb_w_plv0;
            tlb_plv[tlb_w_index][1] <= tlb_w_plv1;
            tlb_d[tlb_w_index]      <= {tlb_w_d1, tlb_w_d0};
            tlb_v[tlb_w_index]      <= {tlb_w_v1, tlb_w_v0};
        end
    end

    // 4M pages ignore the low 9 vppn bits
    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = tlb_e[i] && (tlb_g[i] || tlb_asid[i] == s_asid)
                    && tlb_vppn[i][18:9] == s_vppn[18:9]
                    && (tlb_ps4m[i] || tlb_vppn[i][8:0] == s_vppn[8:0]);
        end
    end

    always_comb begin
        s_found = 1'b0;
        s_index = '0;
        for (int i = 0; i < N; i++) begin
            if (match[i] && !s_found) begin     // lowest index wins
                s_found = 1'b1;
                s_index = lsu_pkg::tlb_idx_t'(i);
            end
        end
    end

    assign odd   = tlb_ps4m[s_index] ? s_va_bit21 : s_va_bit12;
    assign s_ps  = tlb_ps4m[s_index] ? lsu_pkg::PS_4M : lsu_pkg::PS_4K;
    assign s_ppn = tlb_ppn[s_index][odd];
    assign s_plv = tlb_plv[s_index][odd];
    assign s_d   = tlb_d[s_index][odd];
    assign s_v   = tlb_v[s_index][odd];

endmodule

// File: src.f
design/lsu_pkg.sv
design/tlb_lookup.sv
design/addr_xlate.sv
design/ex_stage.sv
design/mem_stage.sv
design/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

// File: tests/lsu_props.sv
`timescale 1ns/1ps

module lsu_props (
    input logic        clk,
    input logic        resetn,
    input logic        data_sram_req,
    input logic        data_sram_addr_ok,
    input logic        data_sram_wr,
    input logic [31:0] data_sram_addr,
    input logic [31:0] data_sram_wdata,
    input logic        data_sram_data_ok,
    input logic        wb_valid,
    input logic        mem_discard,
    input logic        mem_allowin
);
    logic req_pending;   // accepted on the bus, data_ok not seen yet

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_pending <= 1'b0;
        end else if (data_sram_req && data_sram_addr_ok) begin
            req_pending <= 1'b1;
        end else if (data_sram_data_ok) begin
            req_pending <= 1'b0;
        end
    end

    a_req_reset: assert property (@(posedge clk) !resetn |=> !data_sram_req)
        else $error("request raised right after reset");
    a_wb_reset: assert property (@(posedge clk) !resetn |=> !wb_valid)
        else $error("writeback raised right after reset");

    // a held request keeps its payload until accepted
    a_req_stable: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_req && !data_sram_addr_ok |=> !data_sram_req
            || ($stable(data_sram_addr) && $stable(data_sram_wr) && $stable(data_sram_wdata)))
        else $error("bus request changed while waiting for addr_ok");

    // flushed access owns the next data_ok
    a_wb_discard: assert property (@(posedge clk) disable iff (!resetn)
        mem_discard |-> !wb_valid)
        else $error("writeback from a flushed access");

    a_mem_blocked: assert property (@(posedge clk) disable iff (!resetn)
        req_pending && !data_sram_data_ok |-> !mem_allowin)
        else $error("mem stage open while its request is outstanding");
endmodule

bind lsu_top lsu_props u_props (
    .clk               (clk),
    .resetn            (resetn),
    .data_sram_req     (data_sram_req),
    .data_sram_addr_ok (data_sram_addr_ok),
    .data_sram_wr      (data_sram_wr),
    .data_sram_addr    (data_sram_addr),
    .data_sram_wdata   (data_sram_wdata),
    .data_sram_data_ok (data_sram_data_ok),
    .wb_valid          (wb_valid),
    .mem_discard       (u_mem.mem_discard),
    .mem_allowin       (mem_allowin)
);

// File: tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    typedef struct packed {
        lsu_pkg::reg_idx_t rd;
        lsu_pkg::mem_op_t  op;
        logic              exc;
        lsu_pkg::ecode_t   code;
        lsu_pkg::addr_t    va;
        lsu_pkg::addr_t    pa;
        lsu_pkg::word_t    sd;
    } exp_t;

    logic clk = 0, resetn = 0, flush = 0, in_valid = 0;
    lsu_pkg::mem_op_t in_op = lsu_pkg::OP_LD_W;
    lsu_pkg::word_t in_base = 0, in_offset = 0, in_st_data = 0;
    lsu_pkg::reg_idx_t in_rd = 0;
    logic in_allowin, crmd_pg = 0, dmw0_plv_met = 0, dmw1_plv_met = 0;
    lsu_pkg::plv_t crmd_plv = 0;
    lsu_pkg::asid_t asid = 0;
    logic [2:0] dmw0_vseg = 0, dmw0_pseg = 0, dmw1_vseg = 0, dmw1_pseg = 0;
    logic tlb_we = 0, tlb_w_ps4m = 0, tlb_w_g = 0;
    lsu_pkg::tlb_idx_t tlb_w_index = 0;
    lsu_pkg::vppn_t tlb_w_vppn = 0;
    lsu_pkg::asid_t tlb_w_asid = 0;
    lsu_pkg::ppn_t tlb_w_ppn0 = 0, tlb_w_ppn1 = 0;
    lsu_pkg::plv_t tlb_w_plv0 = 0, tlb_w_plv1 = 0;
    logic tlb_w_d0 = 0, tlb_w_d1 = 0, tlb_w_v0 = 0, tlb_w_v1 = 0;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok = 0, data_sram_data_ok = 0;
    logic [1:0] data_sram_size;
    logic [3:0] data_sram_wstrb;
    lsu_pkg::addr_t data_sram_addr;
    lsu_pkg::word_t data_sram_wdata, data_sram_rdata = 0;
    logic wb_valid, wb_we, wb_excep;
    lsu_pkg::reg_idx_t wb_rd;
    lsu_pkg::word_t wb_data;
    lsu_pkg::ecode_t wb_ecode;
    lsu_pkg::addr_t wb_badv;

    integer seed = 32'hf29ba834;
    int errors = 0, aok_wait = 0;
    lsu_pkg::word_t mem_model [1024];
    exp_t q [$];
    int rsp_dly [$];
    lsu_pkg::word_t rsp_data [$];
    lsu_pkg::vppn_t sh_vppn [16];
    lsu_pkg::asid_t sh_asid [16];
    lsu_pkg::ppn_t sh_ppn [16][2];
    lsu_pkg::plv_t sh_plv [16][2];
    logic sh_e [16], sh_ps4m [16], sh_g [16], sh_d [16][2], sh_v [16][2];

    lsu_top UUT (.*);

    always #10 clk = ~clk;

    initial begin   // watchdog
        #(16 * 20 + 400 * 12 * 20);
        errors++;
        $display("watchdog timed out before all results came back");
        $display("errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

    function automatic int rand_below(int k);
        return ($random(seed) & 32'h7fffffff) % k;
    endfunction

    function automatic logic [1:0] size_of(lsu_pkg::mem_op_t op);
        if (op inside {lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_ST_B}) return 2'd0;
        if (op inside {lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_HU, lsu_pkg::OP_ST_H}) return 2'd1;
        return 2'd2;
    endfunction

    task automatic report_mismatch(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // reference translation with the shadow tlb, ALE overrides it
    function automatic exp_t predict(lsu_pkg::mem_op_t op, lsu_pkg::addr_t va,
                                     lsu_pkg::reg_idx_t rd, lsu_pkg::word_t sd);
        exp_t e;
        logic st, hit, odd;
        logic [1:0] sz;
        st = op >= lsu_pkg::OP_ST_B;
        sz = size_of(op);
        e = '{rd: rd, op: op, exc: 1'b0, code: '0, va: va, pa: va, sd: sd};
        if (crmd_pg && dmw0_plv_met && dmw0_vseg == va[31:29]) begin
            e.pa = {dmw0_pseg, va[28:0]};
        end else if (crmd_pg && dmw1_plv_met && dmw1_vseg == va[31:29]) begin
            e.pa = {dmw1_pseg, va[28:0]};
        end else if (crmd_pg) begin
            hit = 1'b0;
            for (int k = 0; k < 16; k++) begin
                if (!hit && sh_e[k] && (sh_g[k] || sh_asid[k] == asid)
                        && sh_vppn[k][18:9] == va[31:22]
                        && (sh_ps4m[k] || sh_vppn[k][8:0] == va[21:13])) begin
                    hit = 1'b1;
                    odd = sh_ps4m[k] ? va[21] : va[12];
                    e.pa = sh_ps4m[k] ? {sh_ppn[k][odd][19:9], va[20:0]}
                                      : {sh_ppn[k][odd], va[11:0]};
                    e.exc = 1'b1;
                    if (!sh_v[k][odd]) e.code = st ? lsu_pkg::ECODE_PIS : lsu_pkg::ECODE_PIL;
                    else if (sh_plv[k][odd] > crmd_plv) e.code = lsu_pkg::ECODE_PPI;
                    else if (st && !sh_d[k][odd]) e.code = lsu_pkg::ECODE_PME;
                    else e.exc = 1'b0;
                end
            end
            if (!hit) begin
                e.exc  = 1'b1;
                e.code = lsu_pkg::ECODE_TLBR;
            end
        end
        if ((sz == 2'd1 && va[0]) || (sz == 2'd2 && va[1:0] != 2'b00)) begin
            e.exc  = 1'b1;
            e.code = lsu_pkg::ECODE_ALE;
        end
        return e;
    endfunction

    task automatic check_writeback();
        exp_t e;
        lsu_pkg::word_t w;
        logic ld;
        if (q.size() == 0) begin
            report_mismatch("writeback with no instruction expected");
            return;
        end
        e = q.pop_front();
        ld = e.op < lsu_pkg::OP_ST_B;
        if (wb_rd != e.rd || wb_excep != e.exc || wb_we != (ld && !e.exc))
            report_mismatch($sformatf("rd/excep/we %0d %b %b", wb_rd, wb_excep, wb_we));
        if (e.exc && (wb_ecode != e.code || wb_badv != e.va))
            report_mismatch($sformatf("ecode %h badv %h, want %h %h",
                                      wb_ecode, wb_badv, e.code, e.va));
        if (ld && !e.exc) begin
            w = mem_model[e.pa[11:2]] >> (8 * e.va[1:0]);
            case (e.op)
                lsu_pkg::OP_LD_B:  w = {{24{w[7]}}, w[7:0]};
                lsu_pkg::OP_LD_BU: w = {24'b0, w[7:0]};
                lsu_pkg::OP_LD_H:  w = {{16{w[15]}}, w[15:0]};
                lsu_pkg::OP_LD_HU: w = {16'b0, w[15:0]};
                default: ;
            endcase
            if (wb_data != w) report_mismatch($sformatf("load data %h, want %h", wb_data, w));
        end
    endtask

    task automatic check_accept();
        exp_t e;
        logic [3:0] mask;
        lsu_pkg::word_t lanes;
        e = q[$];                                    // the instruction sitting in ex
        mask = 4'b1111;
        if (size_of(e.op) != 2'd2)
            mask = (size_of(e.op) == 2'd0 ? 4'b0001 : 4'b0011) << e.va[1:0];
        lanes = e.sd << (8 * e.va[1:0]);
        if (e.exc) report_mismatch("excepting access issued a bus request");
        if (data_sram_addr != e.pa)
            report_mismatch($sformatf("bus addr %h, want %h", data_sram_addr, e.pa));
        if (data_sram_wr != (e.op >= lsu_pkg::OP_ST_B)) report_mismatch("bus wr wrong");
        if (data_sram_size != size_of(e.op))
            report_mismatch($sformatf("bus size %0d, want %0d", data_sram_size, size_of(e.op)));
        if (e.op >= lsu_pkg::OP_ST_B) begin
            if (data_sram_wstrb != mask) report_mismatch($sformatf("wstrb %b", data_sram_wstrb));
            for (int b = 0; b < 4; b++) begin
                if (mask[b] && data_sram_wdata[8*b +: 8] != lanes[8*b +: 8])
                    report_mismatch($sformatf("wdata lane %0d", b));
                if (mask[b]) mem_model[e.pa[11:2]][8*b +: 8] = lanes[8*b +: 8];
            end
        end
        rsp_dly.push_back(1 + rand_below(4));
        rsp_data.push_back(mem_model[data_sram_addr[11:2]]);
        aok_wait = rand_below(4);
    endtask

    function automatic lsu_pkg::addr_t pick_vaddr(logic paged);
        lsu_pkg::addr_t va;
        int kind;
        va = $random(seed);
        kind = rand_below(8);
        if (paged && kind < 1) va[31:29] = 3'h4;                     // dmw0 window
        else if (paged && kind < 2) va[31:29] = 3'h5;                // dmw1 window
        else if (paged && kind < 3) va[31:29] = 3'h2;                // tlb miss
        else if (paged) va[31:13] = sh_vppn[rand_below(8)];
        return va;
    endfunction

    task automatic run_phase(logic paged, int n);
        int issued;
        logic sent;
        lsu_pkg::addr_t va;
        issued = 0;
        sent = 1'b0;
        while (issued < n || in_valid || q.size() != 0 || rsp_dly.size() != 0) begin
            @(negedge clk);
            crmd_pg = paged;
            if (sent) in_valid = 1'b0;
            if (!in_valid && issued < n && rand_below(2) == 0) begin
                in_op = lsu_pkg::mem_op_t'(rand_below(8));
                va = pick_vaddr(paged);
                if (rand_below(4) != 0) va[1:0] = va[1:0] & ~size_of(in_op);   // mostly aligned
                if (size_of(in_op) == 2'd2 && va[1:0] != 0 && rand_below(2) == 0) va[1:0] = 0;
                in_base = $random(seed);
                in_offset = va - in_base;
                in_st_data = $random(seed);
                in_rd = rand_below(32);
                in_valid = 1'b1;
                issued++;
            end
            flush = issued < n && rand_below(32) == 0;
            data_sram_addr_ok = aok_wait == 0;
            data_sram_data_ok = 1'b0;
            if (rsp_dly.size() != 0) begin
                if (rsp_dly[0] > 0) rsp_dly[0]--;
                data_sram_data_ok = rsp_dly[0] == 0;
                data_sram_rdata = rsp_data[0];
            end
            #9;                                      // just before the rising edge
            if (wb_valid) check_writeback();
            if (data_sram_req && data_sram_addr_ok) check_accept();
            else if (data_sram_req && aok_wait > 0) aok_wait--;
            if (data_sram_data_ok) begin
                void'(rsp_dly.pop_front());
                void'(rsp_data.pop_front());
            end
            sent = in_valid && in_allowin;
            if (sent) q.push_back(predict(in_op, in_base + in_offset, in_rd, in_st_data));
            if (flush) q.delete();                   // ex and mem are both dropped
        end
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) mem_model[i] = i * 32'h9e3779b1 ^ 32'h5a5a_0000;
        for (int i = 0; i < 16; i++) sh_e[i] = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        asid = 10'h2a;
        crmd_plv = 2'd1;
        {dmw0_plv_met, dmw0_vseg, dmw0_pseg} = {1'b1, 3'h4, 3'h0};
        {dmw1_plv_met, dmw1_vseg, dmw1_pseg} = {1'b1, 3'h5, 3'h1};
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            tlb_we = 1'b1;
            tlb_w_index = i;
            tlb_w_vppn = {3'b001, 4'(i), 12'($random(seed))};
            tlb_w_ps4m = i[0];
            tlb_w_g = rand_below(2);
            tlb_w_asid = rand_below(4) == 0 ? 10'h15 : 10'h2a;
            {tlb_w_ppn0, tlb_w_ppn1} = {20'($random(seed)), 20'($random(seed))};
            tlb_w_plv0 = rand_below(4) == 0 ? 2'd2 : 2'd0;
            tlb_w_plv1 = rand_below(4) == 0 ? 2'd3 : 2'd1;
            {tlb_w_v0, tlb_w_v1} = {rand_below(8) != 0, rand_below(8) != 0};
            {tlb_w_d0, tlb_w_d1} = {rand_below(4) != 0, rand_below(4) != 0};
            sh_e[i] = 1'b1;
            sh_vppn[i] = tlb_w_vppn;
            sh_ps4m[i] = tlb_w_ps4m;
            sh_g[i] = tlb_w_g;
            sh_asid[i] = tlb_w_asid;
            sh_ppn[i] = '{tlb_w_ppn0, tlb_w_ppn1};
            sh_plv[i] = '{tlb_w_plv0, tlb_w_plv1};
            sh_d[i] = '{tlb_w_d0, tlb_w_d1};
            sh_v[i] = '{tlb_w_v0, tlb_w_v1};
        end
        @(negedge clk);
        tlb_we = 1'b0;
        run_phase(1'b0, 200);
        run_phase(1'b1, 200);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule
